//--- include/sweep_acq_defines.svh
`ifndef SWEEP_ACQ_DEFINES_SVH
`define SWEEP_ACQ_DEFINES_SVH

`define SWEEP_SAMPLE_W   16  // adc sample
`define SWEEP_FREQ_W     24  // synthesizer tuning word
`define SWEEP_CNT_W      16  // point and settle counters
`define SWEEP_FIFO_DEPTH 16

`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32

// byte offsets
`define REG_CTRL   8'h00  // bit 0 = start
`define REG_START  8'h04
`define REG_STEP   8'h08
`define REG_POINTS 8'h0C
`define REG_SETTLE 8'h10
`define REG_STATUS 8'h14  // busy, done, empty, full, level at 12:8
`define REG_DATA   8'h18  // read pops one sample

`endif

//--- hdl/sweep_acq_pkg.sv
`include "sweep_acq_defines.svh"

package sweep_acq_pkg;

  typedef logic [`SWEEP_SAMPLE_W-1:0] sample_t;
  typedef logic [`SWEEP_FREQ_W-1:0] freq_code_t;
  typedef logic [`SWEEP_CNT_W-1:0] cnt_t;
  typedef logic [$clog2(`SWEEP_FIFO_DEPTH+1)-1:0] fifo_level_t;  // 0..depth
  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [1:0] axil_resp_t;

  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

  typedef struct packed {
    freq_code_t start_code;
    freq_code_t step_code;
    cnt_t       points;
    cnt_t       settle;
  } sweep_cfg_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_SETTLE,
    SEQ_CAPTURE,
    SEQ_STEP
  } seq_state_t;

endpackage

//--- hdl/sweep_acq_fifo.sv
`timescale 1ns/10ps
`include "sweep_acq_defines.svh"

module sweep_acq_fifo #(
  parameter int DEPTH = `SWEEP_FIFO_DEPTH
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wr_en,
  input  sweep_acq_pkg::sample_t      wdata,
  input  logic                        rd_en,
  output sweep_acq_pkg::sample_t      rdata,
  output logic                        full,
  output logic                        empty,
  output sweep_acq_pkg::fifo_level_t  level
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] PTR_ONE = 1;

  sweep_acq_pkg::sample_t mem [DEPTH];

  logic [AW:0] wr_ptr;  // msb is the wrap bit
  logic [AW:0] rd_ptr;
  logic        do_wr;
  logic        do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // same index, wrap bits differ => full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign level = sweep_acq_pkg::fifo_level_t'(wr_ptr - rd_ptr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + PTR_ONE;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + PTR_ONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wdata;
    end
    if (do_rd) begin
      rdata <= mem[rd_ptr[AW-1:0]];  // valid the cycle after rd_en
    end
  end

  // producers are expected to respect the flags
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !wr_en)
    else $error("fifo written while full");

  a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
    empty |-> !rd_en)
    else $error("fifo read while empty");

endmodule

//--- hdl/sweep_sequencer.sv
`timescale 1ns/10ps

module sweep_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sweep_acq_pkg::sweep_cfg_t  cfg,
  input  logic                       start,
  input  sweep_acq_pkg::sample_t     adc_data,
  input  logic                       adc_valid,
  input  logic                       fifo_full,
  output sweep_acq_pkg::freq_code_t  freq_code,
  output logic                       freq_load,
  output logic                       wr_en,
  output sweep_acq_pkg::sample_t     wdata,
  output logic                       busy,
  output logic                       done
);

  sweep_acq_pkg::seq_state_t state;
  sweep_acq_pkg::cnt_t       settle_cnt;
  sweep_acq_pkg::cnt_t       pts_left;
  logic                      take;

  // accept a sample only when the fifo has room
  assign take = (state == sweep_acq_pkg::SEQ_CAPTURE) && adc_valid && !fifo_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= sweep_acq_pkg::SEQ_IDLE;
      freq_code  <= '0;
      freq_load  <= 1'b0;
      wr_en      <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
      settle_cnt <= '0;
      pts_left   <= '0;
    end else begin
      freq_load <= 1'b0;
      wr_en     <= 1'b0;
      case (state)
        sweep_acq_pkg::SEQ_IDLE: begin
          if (start) begin
            if (cfg.points == '0) begin
              done <= 1'b1;  // empty sweep, no loads
            end else begin
              done       <= 1'b0;
              busy       <= 1'b1;
              freq_code  <= cfg.start_code;
              freq_load  <= 1'b1;
              settle_cnt <= '0;
              pts_left   <= cfg.points;
              state      <= sweep_acq_pkg::SEQ_SETTLE;
            end
          end
        end
        sweep_acq_pkg::SEQ_SETTLE: begin
          if (settle_cnt == cfg.settle) begin
            state <= sweep_acq_pkg::SEQ_CAPTURE;
          end else begin
            settle_cnt <= settle_cnt + sweep_acq_pkg::cnt_t'(1);
          end
        end
        sweep_acq_pkg::SEQ_CAPTURE: begin
          if (take) begin
            wr_en <= 1'b1;  // push lands next cycle
            state <= sweep_acq_pkg::SEQ_STEP;
          end
        end
        sweep_acq_pkg::SEQ_STEP: begin
          if (pts_left == sweep_acq_pkg::cnt_t'(1)) begin
            busy  <= 1'b0;
            done  <= 1'b1;
            state <= sweep_acq_pkg::SEQ_IDLE;
          end else begin
            pts_left   <= pts_left - sweep_acq_pkg::cnt_t'(1);
            freq_code  <= freq_code + cfg.step_code;  // wraps mod 2^24
            freq_load  <= 1'b1;
            settle_cnt <= '0;
            state      <= sweep_acq_pkg::SEQ_SETTLE;
          end
        end
        default: state <= sweep_acq_pkg::SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      wdata <= adc_data;
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !fifo_full)
    else $error("sample pushed into a full fifo");

  a_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
    freq_load |-> busy)
    else $error("freq_load outside a sweep");

endmodule

//--- hdl/sweep_acq_regs.sv
`timescale 1ns/10ps
`include "sweep_acq_defines.svh"

module sweep_acq_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  sweep_acq_pkg::axil_req_t     axil_req,
  output sweep_acq_pkg::axil_rsp_t     axil_rsp,
  output sweep_acq_pkg::sweep_cfg_t    cfg,
  output logic                         start,
  input  logic                         busy,
  input  logic                         done,
  output logic                         fifo_rd_en,
  input  sweep_acq_pkg::sample_t       fifo_rdata,
  input  logic                         fifo_empty,
  input  logic                         fifo_full,
  input  sweep_acq_pkg::fifo_level_t   fifo_level
);

  logic                      wr_fire;
  logic                      rd_fire;
  logic                      bvalid;
  logic                      rvalid;
  logic                      rd_pend;  // AR taken, data next cycle
  logic                      rd_pop;
  sweep_acq_pkg::axil_addr_t rd_addr;
  sweep_acq_pkg::axil_data_t rdata;
  sweep_acq_pkg::axil_data_t status;
  sweep_acq_pkg::axil_data_t rd_word;

  // aw and w taken together
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_fire = axil_req.arvalid && !rd_pend && !rvalid;

  assign fifo_rd_en = rd_fire && (axil_req.araddr == `REG_DATA) && !fifo_empty;

  always_comb begin
    status = '0;
    status[0] = busy;
    status[1] = done;
    status[2] = fifo_empty;
    status[3] = fifo_full;
    status[8 +: $bits(sweep_acq_pkg::fifo_level_t)] = fifo_level;
  end

  always_comb begin
    case (rd_addr)
      `REG_START:  rd_word = sweep_acq_pkg::axil_data_t'(cfg.start_code);
      `REG_STEP:   rd_word = sweep_acq_pkg::axil_data_t'(cfg.step_code);
      `REG_POINTS: rd_word = sweep_acq_pkg::axil_data_t'(cfg.points);
      `REG_SETTLE: rd_word = sweep_acq_pkg::axil_data_t'(cfg.settle);
      `REG_STATUS: rd_word = status;
      `REG_DATA:   rd_word = rd_pop ? sweep_acq_pkg::axil_data_t'(fifo_rdata) : '0;
      default:     rd_word = '0;  // ctrl and holes
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg     <= '0;
      start   <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rd_pend <= 1'b0;
      rd_pop  <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (axil_req.awaddr)
          `REG_CTRL:   start <= axil_req.wdata[0] && !busy;
          `REG_START:  cfg.start_code <= sweep_acq_pkg::freq_code_t'(axil_req.wdata);
          `REG_STEP:   cfg.step_code <= sweep_acq_pkg::freq_code_t'(axil_req.wdata);
          `REG_POINTS: cfg.points <= sweep_acq_pkg::cnt_t'(axil_req.wdata);
          `REG_SETTLE: cfg.settle <= sweep_acq_pkg::cnt_t'(axil_req.wdata);
          default: ;  // ignored, still OKAY
        endcase
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end

      rd_pend <= rd_fire;
      rd_pop  <= fifo_rd_en;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_addr <= axil_req.araddr;
    end
    if (rd_pend) begin
      rdata <= rd_word;
    end
  end

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bresp   = 2'b00;  // OKAY
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = 2'b00;
  assign axil_rsp.rvalid  = rvalid;

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !axil_req.rready |=> rvalid)
    else $error("rvalid dropped before rready");

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !axil_req.bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

//--- hdl/sweep_acq_top.sv
`timescale 1ns/10ps

module sweep_acq_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sweep_acq_pkg::axil_req_t   axil_req,
  output sweep_acq_pkg::axil_rsp_t   axil_rsp,
  input  sweep_acq_pkg::sample_t     adc_data,
  input  logic                       adc_valid,
  output sweep_acq_pkg::freq_code_t  freq_code,
  output logic                       freq_load
);

  sweep_acq_pkg::sweep_cfg_t  cfg;
  logic                       start;
  logic                       busy;
  logic                       done;
  logic                       fifo_wr_en;
  sweep_acq_pkg::sample_t     fifo_wdata;
  logic                       fifo_rd_en;
  sweep_acq_pkg::sample_t     fifo_rdata;
  logic                       fifo_full;
  logic                       fifo_empty;
  sweep_acq_pkg::fifo_level_t fifo_level;

  sweep_acq_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .cfg        (cfg),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .fifo_rd_en (fifo_rd_en),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .fifo_level (fifo_level)
  );

  sweep_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .start     (start),
    .adc_data  (adc_data),
    .adc_valid (adc_valid),
    .fifo_full (fifo_full),
    .freq_code (freq_code),
    .freq_load (freq_load),
    .wr_en     (fifo_wr_en),
    .wdata     (fifo_wdata),
    .busy      (busy),
    .done      (done)
  );

  sweep_acq_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (fifo_wr_en),
    .wdata (fifo_wdata),
    .rd_en (fifo_rd_en),
    .rdata (fifo_rdata),
    .full  (fifo_full),
    .empty (fifo_empty),
    .level (fifo_level)
  );

endmodule

//--- bench/sweep_acq_tb.sv
`timescale 1ns/10ps
`include "sweep_acq_defines.svh"

module sweep_acq_tb;

  localparam int P1 = 6;   // wrap sweep
  localparam int S1 = 3;
  localparam int P2 = 20;  // overruns the fifo
  localparam int S2 = 0;
  localparam int unsigned TIMEOUT_CYCLES = P1 * (S1 + 20) + P2 * (S2 + 20) + 2000;
  localparam sweep_acq_pkg::fifo_level_t FULL_LEVEL =
    sweep_acq_pkg::fifo_level_t'(`SWEEP_FIFO_DEPTH);
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                        clk;
  logic                        rst_n;
  sweep_acq_pkg::axil_req_t    req;
  sweep_acq_pkg::axil_rsp_t    rsp;
  sweep_acq_pkg::sample_t      adc_data;
  logic                        adc_valid;
  sweep_acq_pkg::freq_code_t   freq_code;
  logic                        freq_load;

  logic [15:0]                 adc_lfsr;
  logic [15:0]                 adc_bits;
  logic [1:0]                  gap_cnt;
  logic [15:0]                 hs_lfsr;
  string                       test_name;
  logic                        rd_chk;
  sweep_acq_pkg::axil_data_t   rd_exp;
  sweep_acq_pkg::axil_addr_t   rd_addr_q;
  sweep_acq_pkg::axil_data_t   rd_last;
  sweep_acq_pkg::axil_data_t   exp_word;
  logic                        chk_loads;
  int unsigned                 cycles;

  // reference model state
  sweep_acq_pkg::freq_code_t   sh_start;
  sweep_acq_pkg::freq_code_t   sh_step;
  sweep_acq_pkg::cnt_t         sh_points;
  sweep_acq_pkg::cnt_t         sh_settle;
  sweep_acq_pkg::freq_code_t   exp_code;
  sweep_acq_pkg::cnt_t         load_cnt;
  sweep_acq_pkg::cnt_t         wait_cnt;
  logic                        armed;
  logic                        take_q;
  sweep_acq_pkg::fifo_level_t  occ;
  sweep_acq_pkg::axil_data_t   pop_exp;
  int                          pop_cnt;
  logic                        ar_hs_q;
  sweep_acq_pkg::sample_t      model_q [$];

  logic aw_hs;
  logic ar_hs;
  logic r_hs;
  logic pop;
  logic model_take;

  sweep_acq_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (req),
    .axil_rsp  (rsp),
    .adc_data  (adc_data),
    .adc_valid (adc_valid),
    .freq_code (freq_code),
    .freq_load (freq_load)
  );

  assign aw_hs      = req.awvalid && req.wvalid && rsp.awready;
  assign ar_hs      = req.arvalid && rsp.arready;
  assign r_hs       = rsp.rvalid && req.rready;
  assign pop        = ar_hs && (req.araddr == `REG_DATA) && (occ != '0);
  assign model_take = armed && (wait_cnt == '0) && adc_valid && (occ != FULL_LEVEL);
  assign exp_word   = (rd_addr_q == `REG_DATA) ? pop_exp : rd_exp;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] st, input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v[i] = st[0];
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout after %0d cycles, test %s never completed",
                            cycles, test_name));
      end
    end
  end

  // adc stream with random gaps
  initial begin
    adc_valid <= 1'b0;
    adc_data  <= '0;
    gap_cnt   <= '0;
    adc_lfsr  = 16'd17;
    forever begin
      @(posedge clk);
      if (gap_cnt != 2'd0) begin
        adc_valid <= 1'b0;
        gap_cnt   <= gap_cnt - 2'd1;
      end else begin
        draw_bits(adc_lfsr, 16, adc_bits);
        adc_data  <= adc_bits;
        adc_valid <= 1'b1;
        draw_bits(adc_lfsr, 2, adc_bits);
        gap_cnt   <= adc_bits[1:0];
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      sh_start  <= '0;
      sh_step   <= '0;
      sh_points <= '0;
      sh_settle <= '0;
      exp_code  <= '0;
      load_cnt  <= '0;
      wait_cnt  <= '0;
      armed     <= 1'b0;
      take_q    <= 1'b0;
      occ       <= '0;
      pop_exp   <= '0;
      pop_cnt   <= 0;
      ar_hs_q   <= 1'b0;
      model_q.delete();
    end else begin
      ar_hs_q <= ar_hs;
      take_q  <= model_take;  // push lands one cycle after the take
      if (aw_hs) begin
        case (req.awaddr)
          `REG_CTRL: begin
            if (req.wdata[0]) begin
              exp_code <= sh_start;
              load_cnt <= '0;
            end
          end
          `REG_START:  sh_start  <= sweep_acq_pkg::freq_code_t'(req.wdata);
          `REG_STEP:   sh_step   <= sweep_acq_pkg::freq_code_t'(req.wdata);
          `REG_POINTS: sh_points <= sweep_acq_pkg::cnt_t'(req.wdata);
          `REG_SETTLE: sh_settle <= sweep_acq_pkg::cnt_t'(req.wdata);
          default: ;
        endcase
      end
      if (freq_load) begin
        exp_code <= exp_code + sh_step;
        load_cnt <= load_cnt + sweep_acq_pkg::cnt_t'(1);
        wait_cnt <= sh_settle;
        armed    <= 1'b1;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - sweep_acq_pkg::cnt_t'(1);
      end
      if (pop) begin
        pop_exp <= sweep_acq_pkg::axil_data_t'(model_q.pop_front());
        pop_cnt <= pop_cnt + 1;
      end else if (ar_hs && (req.araddr == `REG_DATA)) begin
        pop_exp <= '0;  // empty fifo reads zero
      end
      if (model_take) begin
        armed <= 1'b0;
        model_q.push_back(adc_data);
      end
      if (take_q && !pop) begin
        occ <= occ + sweep_acq_pkg::fifo_level_t'(1);
      end else if (!take_q && pop) begin
        occ <= occ - sweep_acq_pkg::fifo_level_t'(1);
      end
    end
  end

  a_freq_step: assert property (@(posedge clk) disable iff (!rst_n)
    freq_load |-> freq_code == exp_code)
    else abort_run($sformatf("ERROR %s: freq_code expected %h actual %h",
                             test_name, $sampled(exp_code), $sampled(freq_code)));

  a_load_count: assert property (@(posedge clk) disable iff (!rst_n)
    chk_loads |-> load_cnt == sh_points)
    else abort_run($sformatf("ERROR %s: load count expected %0d actual %0d",
                             test_name, $sampled(sh_points), $sampled(load_cnt)));

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    r_hs && rd_chk |-> rsp.rdata == exp_word)
    else abort_run($sformatf("ERROR %s: rdata at %h expected %h actual %h", test_name,
                             $sampled(rd_addr_q), $sampled(exp_word), $sampled(rsp.rdata)));

  a_b_timing: assert property (@(posedge clk) disable iff (!rst_n)
    aw_hs |=> rsp.bvalid)
    else abort_run("bvalid did not rise one cycle after the write was accepted");

  a_r_early: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |=> !rsp.rvalid)
    else abort_run("rvalid rose one cycle after the read address, one cycle early");

  a_r_timing: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs_q |=> rsp.rvalid)
    else abort_run("rvalid did not rise two cycles after the read address");

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.bvalid && !req.bready |=> rsp.bvalid)
    else abort_run("bvalid dropped while bready was low");

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
    else abort_run("rvalid or rdata changed while rready was low");

  a_aw_w_together: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.awready == rsp.wready)
    else abort_run("write address and write data were not accepted in the same cycle");

  a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.bvalid |-> rsp.bresp == RESP_OKAY)
    else abort_run($sformatf("ERROR %s: bresp expected %h actual %h",
                             test_name, RESP_OKAY, $sampled(rsp.bresp)));

  a_rresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.rvalid |-> rsp.rresp == RESP_OKAY)
    else abort_run($sformatf("ERROR %s: rresp expected %h actual %h",
                             test_name, RESP_OKAY, $sampled(rsp.rresp)));

  task automatic write_reg(input sweep_acq_pkg::axil_addr_t addr,
                           input sweep_acq_pkg::axil_data_t data);
    logic [15:0] bits;
    req.awaddr  <= addr;
    req.wdata   <= data;
    req.awvalid <= 1'b1;
    req.wvalid  <= 1'b1;
    req.bready  <= 1'b0;
    do begin
      @(posedge clk);
    end while (!rsp.awready);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    draw_bits(hs_lfsr, 3, bits);
    repeat (bits[2:0]) @(posedge clk);  // hold bready low a while
    req.bready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!rsp.bvalid);
    req.bready <= 1'b0;
  endtask

  task automatic read_reg(input sweep_acq_pkg::axil_addr_t addr, input logic check,
                          input sweep_acq_pkg::axil_data_t exp);
    logic [15:0] bits;
    rd_chk      <= check;
    rd_exp      <= exp;
    rd_addr_q   <= addr;
    req.araddr  <= addr;
    req.arvalid <= 1'b1;
    req.rready  <= 1'b0;
    do begin
      @(posedge clk);
    end while (!rsp.arready);
    req.arvalid <= 1'b0;
    draw_bits(hs_lfsr, 3, bits);
    repeat (bits[2:0]) @(posedge clk);
    req.rready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!rsp.rvalid);
    rd_last = rsp.rdata;
    req.rready <= 1'b0;
  endtask

  task automatic wait_sweep_done();
    do begin
      read_reg(`REG_STATUS, 1'b0, '0);
    end while (!rd_last[1]);
  endtask

  task automatic pulse_load_check();
    chk_loads <= 1'b1;
    @(posedge clk);
    chk_loads <= 1'b0;
  endtask

  task automatic drain_samples(input int n);
    int target;
    target = pop_cnt + n;
    while (pop_cnt < target) begin
      read_reg(`REG_DATA, 1'b1, '0);
    end
  endtask

  initial begin
    req       <= '0;
    chk_loads <= 1'b0;
    rd_chk    <= 1'b0;
    rd_exp    <= '0;
    rd_addr_q <= '0;
    test_name <= "reset status";
    rd_last   = '0;
    hs_lfsr   = 16'd17;
    @(posedge clk);
    while (!rst_n) @(posedge clk);

    read_reg(`REG_STATUS, 1'b1, 32'h0000_0004);  // empty only
    test_name <= "empty read";
    read_reg(`REG_DATA, 1'b1, '0);
    read_reg(`REG_STATUS, 1'b1, 32'h0000_0004);

    test_name <= "register readback";
    write_reg(`REG_START, 32'h00FF_FF00);
    write_reg(`REG_STEP, 32'h0000_0060);
    write_reg(`REG_POINTS, 32'(P1));
    write_reg(`REG_SETTLE, 32'(S1));
    write_reg(8'h1C, 32'hDEAD_BEEF);  // hole in the map
    read_reg(`REG_START, 1'b1, 32'h00FF_FF00);
    read_reg(`REG_STEP, 1'b1, 32'h0000_0060);
    read_reg(`REG_POINTS, 1'b1, 32'(P1));
    read_reg(`REG_SETTLE, 1'b1, 32'(S1));
    read_reg(`REG_STATUS, 1'b1, 32'h0000_0004);

    test_name <= "freq sweep";
    write_reg(`REG_CTRL, 32'h0000_0001);
    wait_sweep_done();
    pulse_load_check();
    drain_samples(P1);
    read_reg(`REG_STATUS, 1'b1, 32'h0000_0006);

    test_name <= "back-pressure";
    write_reg(`REG_START, 32'h0000_0010);
    write_reg(`REG_STEP, 32'h0001_2345);
    write_reg(`REG_POINTS, 32'(P2));
    write_reg(`REG_SETTLE, 32'(S2));
    write_reg(`REG_CTRL, 32'h0000_0001);
    while (occ != FULL_LEVEL) @(posedge clk);
    read_reg(`REG_STATUS, 1'b1, 32'h0000_1009);  // busy, full, level 16
    drain_samples(P2);
    wait_sweep_done();
    pulse_load_check();
    read_reg(`REG_STATUS, 1'b1, 32'h0000_0006);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hdl/sweep_acq_pkg.sv
hdl/sweep_acq_fifo.sv
hdl/sweep_sequencer.sv
hdl/sweep_acq_regs.sv
hdl/sweep_acq_top.sv
bench/sweep_acq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sweep_acq_tb
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
